// File: design/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // ========================================================================
    // host command set and reply codes
    // ========================================================================
    typedef enum logic [7:0] {
        CMD_NOP        = 8'h00,
        CMD_ECHO       = 8'h01,
        CMD_TOGGLE_LED = 8'h02,
        CMD_READ_FLASH = 8'h08,
        CMD_ECHO_CC    = 8'hCC
    } dbg_cmd_e;

    localparam logic [7:0] REPLY_ZERO  = 8'h00;
    localparam logic [7:0] REPLY_BAD   = 8'hFF;
    localparam logic [7:0] REPLY_BUSY  = 8'hFE;
    localparam logic [7:0] REPLY_READY = 8'hFD;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ECHO,
        ST_ADDR,
        ST_WAIT_FLASH,
        ST_SEND_DATA
    } dbg_state_e;

    typedef enum logic [1:0] {
        FL_IDLE,
        FL_SHIFT_OUT,
        FL_SHIFT_IN,
        FL_DONE
    } flash_state_e;

    // ========================================================================
    // flash and SPI timing
    // ========================================================================
    localparam logic [7:0] FLASH_READ_OP = 8'h03;
    localparam int FLASH_ADDR_W   = 24;
    // opcode plus address, then one data byte back
    localparam int FLASH_OUT_BITS = 8 + FLASH_ADDR_W;
    localparam int FLASH_CYCLES   = FLASH_OUT_BITS + 8;

    localparam int FLASH_HALF_PERIOD = 2;
    localparam int FLASH_DIV_W = (FLASH_HALF_PERIOD > 1) ? $clog2(FLASH_HALF_PERIOD) : 1;

    localparam int SPI_SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: design/byte_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte stream between the SPI target and the command FSM
interface byte_link_if;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_take;

    modport target (
        output rx_data,
        output rx_valid,
        output tx_take,
        input  tx_data
    );

    modport host (
        input  rx_data,
        input  rx_valid,
        input  tx_take,
        output tx_data
    );
endinterface

`default_nettype wire

// File: design/flash_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-byte flash read request and response
interface flash_req_if;
    logic                           req_valid;
    logic                           req_ready;
    logic [dbg_pkg::FLASH_ADDR_W-1:0] req_addr;
    logic                           rsp_valid;
    logic [7:0]                     rsp_data;

    modport requester (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport reader (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );
endinterface

`default_nettype wire

// File: design/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    output logic       rise,
    output logic       fall,
    output logic [5:0] bit_idx,
    output logic       last_bit
);

    logic [dbg_pkg::FLASH_DIV_W-1:0] div_cnt;
    logic                            phase;
    logic                            half_end;

    assign half_end = run && (div_cnt == dbg_pkg::FLASH_DIV_W'(dbg_pkg::FLASH_HALF_PERIOD - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            phase   <= 1'b0;
            bit_idx <= 6'd0;
        end else if (!run) begin
            div_cnt <= '0;
            phase   <= 1'b0;
            bit_idx <= 6'd0;
        end else if (half_end) begin
            div_cnt <= '0;
            phase   <= ~phase;
            // a period is complete once sclk drops again
            if (phase) begin
                bit_idx <= bit_idx + 6'd1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign rise     = half_end & ~phase;
    assign fall     = half_end & phase;
    assign last_bit = fall & (bit_idx == 6'(dbg_pkg::FLASH_CYCLES - 1));

endmodule

`default_nettype wire

// File: design/spi_target.sv
`timescale 1ns/1ps
`default_nettype none

module spi_target (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss_n,
    output logic       miso,
    byte_link_if.target link
);

    // ========================================================================
    // pin synchronizers and edge detect
    // ========================================================================
    // one 3-bit slice per stage, {sclk, mosi, ss_n}
    logic [dbg_pkg::SPI_SYNC_STAGES-1:0][2:0] pin_sync;
    logic       sclk_s;
    logic       mosi_s;
    logic       ss_s;
    logic       sclk_q;
    logic       ss_q;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_fall;

    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       tx_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pin_sync <= {dbg_pkg::SPI_SYNC_STAGES{3'b001}};
            sclk_q   <= 1'b0;
            ss_q     <= 1'b1;
        end else begin
            pin_sync <= {pin_sync[dbg_pkg::SPI_SYNC_STAGES-2:0], {sclk, mosi, ss_n}};
            sclk_q   <= sclk_s;
            ss_q     <= ss_s;
        end
    end

    assign sclk_s = pin_sync[dbg_pkg::SPI_SYNC_STAGES-1][2];
    assign mosi_s = pin_sync[dbg_pkg::SPI_SYNC_STAGES-1][1];
    assign ss_s   = pin_sync[dbg_pkg::SPI_SYNC_STAGES-1][0];

    assign sclk_rise = sclk_s & ~sclk_q;
    assign sclk_fall = ~sclk_s & sclk_q;
    assign ss_fall   = ~ss_s & ss_q;

    // ========================================================================
    // receive side, sample on rising sclk
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt       <= 3'd0;
            link.rx_valid <= 1'b0;
        end else begin
            link.rx_valid <= 1'b0;
            if (ss_s) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    link.rx_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise && !ss_s) begin
            rx_shift <= {rx_shift[6:0], mosi_s};
        end
    end

    // full byte sits in the shifter while rx_valid is high
    assign link.rx_data = rx_shift;

    // ========================================================================
    // transmit side, shift on falling sclk
    // ========================================================================
    // reload at select and on the fall that closes a byte
    assign tx_load = ss_fall | (sclk_fall & ~ss_s & (bit_cnt == 3'd0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_shift <= 8'd0;
        end else if (tx_load) begin
            tx_shift <= link.tx_data;
        end else if (sclk_fall && !ss_s) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign link.tx_take = tx_load;
    assign miso         = tx_shift[7];

endmodule

`default_nettype wire

// File: design/dbg_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fsm (
    input  logic           clk,
    input  logic           rst,
    byte_link_if.host      link,
    flash_req_if.requester flash,
    output logic           led
);

    localparam int ADDR_BYTES = dbg_pkg::FLASH_ADDR_W / 8;

    dbg_pkg::dbg_state_e state;
    logic [1:0]          addr_left;
    logic [7:0]          flash_byte;
    logic                flash_hit;
    logic                reply_pend;

    // ========================================================================
    // command decode and reply selection
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= dbg_pkg::ST_IDLE;
            led             <= 1'b0;
            link.tx_data    <= dbg_pkg::REPLY_ZERO;
            addr_left       <= 2'd0;
            flash.req_valid <= 1'b0;
            flash_hit       <= 1'b0;
            reply_pend      <= 1'b0;
        end else begin
            if (flash.req_valid && flash.req_ready) begin
                flash.req_valid <= 1'b0;
            end
            if (flash.rsp_valid) begin
                flash_hit <= 1'b1;
            end
            if (link.tx_take) begin
                reply_pend <= 1'b0;
            end

            if (link.rx_valid) begin
                reply_pend <= 1'b1;
                case (state)
                    dbg_pkg::ST_IDLE: begin
                        case (dbg_pkg::dbg_cmd_e'(link.rx_data))
                            dbg_pkg::CMD_NOP: begin
                                link.tx_data <= dbg_pkg::REPLY_ZERO;
                            end
                            dbg_pkg::CMD_ECHO: begin
                                link.tx_data <= dbg_pkg::CMD_ECHO;
                                state        <= dbg_pkg::ST_ECHO;
                            end
                            dbg_pkg::CMD_TOGGLE_LED: begin
                                led          <= ~led;
                                link.tx_data <= dbg_pkg::REPLY_ZERO;
                            end
                            dbg_pkg::CMD_ECHO_CC: begin
                                link.tx_data <= dbg_pkg::CMD_ECHO_CC;
                            end
                            dbg_pkg::CMD_READ_FLASH: begin
                                // tell the host how many address bytes follow
                                link.tx_data <= 8'(ADDR_BYTES);
                                addr_left    <= 2'(ADDR_BYTES);
                                state        <= dbg_pkg::ST_ADDR;
                            end
                            default: begin
                                link.tx_data <= dbg_pkg::REPLY_BAD;
                            end
                        endcase
                    end

                    dbg_pkg::ST_ECHO: begin
                        link.tx_data <= link.rx_data;
                        state        <= dbg_pkg::ST_IDLE;
                    end

                    dbg_pkg::ST_ADDR: begin
                        link.tx_data <= {6'd0, addr_left - 2'd1};
                        addr_left    <= addr_left - 2'd1;
                        if (addr_left == 2'd1) begin
                            flash.req_valid <= 1'b1;
                            state           <= dbg_pkg::ST_WAIT_FLASH;
                        end
                    end

                    dbg_pkg::ST_WAIT_FLASH: begin
                        if (flash_hit) begin
                            link.tx_data <= dbg_pkg::REPLY_READY;
                            state        <= dbg_pkg::ST_SEND_DATA;
                        end else begin
                            link.tx_data <= dbg_pkg::REPLY_BUSY;
                        end
                    end

                    dbg_pkg::ST_SEND_DATA: begin
                        link.tx_data <= flash_byte;
                        flash_hit    <= 1'b0;
                        state        <= dbg_pkg::ST_IDLE;
                    end

                    default: begin
                        link.tx_data <= dbg_pkg::REPLY_BAD;
                        state        <= dbg_pkg::ST_IDLE;
                    end
                endcase

                // previous reply never reached the shifter, host was too fast
                if (reply_pend && !link.tx_take) begin
                    link.tx_data <= dbg_pkg::REPLY_BAD;
                end
            end
        end
    end

    // ========================================================================
    // address and flash data capture
    // ========================================================================
    always_ff @(posedge clk) begin
        if (link.rx_valid && state == dbg_pkg::ST_ADDR) begin
            flash.req_addr <= {flash.req_addr[dbg_pkg::FLASH_ADDR_W-9:0], link.rx_data};
        end
        if (flash.rsp_valid) begin
            flash_byte <= flash.rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: design/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
    input  logic        clk,
    input  logic        rst,
    flash_req_if.reader req,
    output logic        cs_n,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso
);

    localparam int OUT_MSB = dbg_pkg::FLASH_OUT_BITS - 1;

    dbg_pkg::flash_state_e state;
    logic [OUT_MSB:0]      tx_shift;
    logic [7:0]            rx_shift;
    logic                  run;
    logic                  rise;
    logic                  fall;
    logic [5:0]            bit_idx;
    logic                  last_bit;

    assign run = (state == dbg_pkg::FL_SHIFT_OUT) || (state == dbg_pkg::FL_SHIFT_IN);

    bit_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .rise     (rise),
        .fall     (fall),
        .bit_idx  (bit_idx),
        .last_bit (last_bit)
    );

    // ========================================================================
    // read sequencer, mode 0
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= dbg_pkg::FL_IDLE;
            cs_n          <= 1'b1;
            sclk          <= 1'b0;
            tx_shift      <= '0;
            req.rsp_valid <= 1'b0;
        end else begin
            req.rsp_valid <= 1'b0;
            if (rise) begin
                sclk <= 1'b1;
            end
            if (fall) begin
                sclk <= 1'b0;
            end

            case (state)
                dbg_pkg::FL_IDLE: begin
                    if (req.req_valid) begin
                        tx_shift <= {dbg_pkg::FLASH_READ_OP, req.req_addr};
                        cs_n     <= 1'b0;
                        state    <= dbg_pkg::FL_SHIFT_OUT;
                    end
                end
                dbg_pkg::FL_SHIFT_OUT: begin
                    // next bit goes out on the falling edge
                    if (fall) begin
                        tx_shift <= {tx_shift[OUT_MSB-1:0], 1'b0};
                        if (bit_idx == 6'(OUT_MSB)) begin
                            state <= dbg_pkg::FL_SHIFT_IN;
                        end
                    end
                end
                dbg_pkg::FL_SHIFT_IN: begin
                    if (last_bit) begin
                        state <= dbg_pkg::FL_DONE;
                    end
                end
                default: begin
                    cs_n          <= 1'b1;
                    req.rsp_valid <= 1'b1;
                    state         <= dbg_pkg::FL_IDLE;
                end
            endcase
        end
    end

    // data byte sampled on rising sclk
    always_ff @(posedge clk) begin
        if (state == dbg_pkg::FL_SHIFT_IN && rise) begin
            rx_shift <= {rx_shift[6:0], miso};
        end
    end

    assign req.req_ready = (state == dbg_pkg::FL_IDLE);
    assign req.rsp_data  = rx_shift;
    assign mosi          = tx_shift[OUT_MSB];

endmodule

`default_nettype wire

// File: design/dbg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bridge (
    input  logic clk,
    input  logic rst,
    input  logic spi_sclk,
    input  logic spi_mosi,
    input  logic spi_ss_n,
    output logic spi_miso,
    output logic flash_cs_n,
    output logic flash_sclk,
    output logic flash_mosi,
    input  logic flash_miso,
    output logic led
);

    byte_link_if link ();
    flash_req_if freq ();

    // ========================================================================
    // host side
    // ========================================================================
    spi_target u_spi (
        .clk  (clk),
        .rst  (rst),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .ss_n (spi_ss_n),
        .miso (spi_miso),
        .link (link)
    );

    dbg_cmd_fsm u_cmd (
        .clk   (clk),
        .rst   (rst),
        .link  (link),
        .flash (freq),
        .led   (led)
    );

    // flash side
    flash_reader u_flash (
        .clk  (clk),
        .rst  (rst),
        .req  (freq),
        .cs_n (flash_cs_n),
        .sclk (flash_sclk),
        .mosi (flash_mosi),
        .miso (flash_miso)
    );

endmodule

`default_nettype wire

// File: sim/dbg_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bridge_checker (
    input logic clk,
    input logic rst,
    input logic rx_valid,
    input logic flash_cs_n,
    input logic flash_sclk,
    input logic flash_mosi,
    input logic led
);

    // failed assertions so far
    int unsigned fail_count = 0;

    // flash clock idles low outside a transfer
    sclk_low_when_idle: assert property (
        @(posedge clk) disable iff (rst) flash_cs_n |-> !flash_sclk
    ) else begin
        $error("flash_sclk high while flash_cs_n is deasserted");
        fail_count++;
    end

    cs_high_in_reset: assert property (
        @(posedge clk) rst |-> flash_cs_n
    ) else begin
        $error("flash_cs_n low during reset");
        fail_count++;
    end

    // led only flips in response to a received byte
    led_after_rx: assert property (
        @(posedge clk) disable iff (rst) (led != $past(led)) |-> $past(rx_valid)
    ) else begin
        $error("led changed without a received byte");
        fail_count++;
    end

    mosi_stable_high: assert property (
        @(posedge clk) disable iff (rst)
            (flash_sclk && $past(flash_sclk)) |-> $stable(flash_mosi)
    ) else begin
        $error("flash_mosi changed while flash_sclk was high");
        fail_count++;
    end

endmodule

bind dbg_bridge dbg_bridge_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .rx_valid   (link.rx_valid),
    .flash_cs_n (flash_cs_n),
    .flash_sclk (flash_sclk),
    .flash_mosi (flash_mosi),
    .led        (led)
);

`default_nettype wire

// File: sim/dbg_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bridge_tb;

    localparam int CLK_PERIOD = 20;
    localparam int HALF_SCLK  = 5;
    localparam int IDLE_CLK   = 10;
    localparam int BYTE_CLK   = 18 * HALF_SCLK + IDLE_CLK + 1;
    localparam int FLASH_CLK  = 2 + 2 * dbg_pkg::FLASH_CYCLES * dbg_pkg::FLASH_HALF_PERIOD;
    localparam int MAX_POLLS  = FLASH_CLK / BYTE_CLK + 4;

    localparam int N_NOP    = 4;
    localparam int N_ECHO   = 4;
    localparam int N_CC     = 3;
    localparam int N_BAD    = 8;
    localparam int N_TOGGLE = 9;
    localparam int N_READ   = 3;
    localparam int N_MIX    = 40;
    localparam int N_TXN    = N_NOP + N_ECHO + N_CC + 2 * N_BAD + N_TOGGLE + N_READ + N_MIX + 1;
    // every transaction counted as a full flash read, then doubled
    localparam longint WATCHDOG_NS = 2 * CLK_PERIOD *
        longint'(16 + N_TXN * (FLASH_CLK + (5 + MAX_POLLS) * BYTE_CLK));

    logic clk;
    logic rst;
    logic spi_sclk;
    logic spi_mosi;
    logic spi_ss_n;
    logic spi_miso;
    logic flash_cs_n;
    logic flash_sclk;
    logic flash_mosi;
    logic flash_miso = 1'b0;
    logic led;

    logic        m_led;
    logic [7:0]  exp_reply;
    logic [23:0] exp_addr;
    int          fl_count;
    logic [31:0] fl_shift;
    logic [7:0]  fl_data;

    dbg_bridge dut (
        .clk        (clk),
        .rst        (rst),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_ss_n   (spi_ss_n),
        .spi_miso   (spi_miso),
        .flash_cs_n (flash_cs_n),
        .flash_sclk (flash_sclk),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso),
        .led        (led)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic logic [7:0] flash_pattern(input logic [23:0] addr);
        return addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    function automatic logic is_known_op(input logic [7:0] op);
        return op == 8'h00 || op == 8'h01 || op == 8'h02 || op == 8'h08 || op == 8'hCC;
    endfunction

    function automatic logic [7:0] idle_reply(input logic [7:0] op);
        case (op)
            dbg_pkg::CMD_NOP:        return 8'h00;
            dbg_pkg::CMD_ECHO:       return 8'h01;
            dbg_pkg::CMD_TOGGLE_LED: return 8'h00;
            dbg_pkg::CMD_READ_FLASH: return 8'h03;
            dbg_pkg::CMD_ECHO_CC:    return 8'hCC;
            default:                 return 8'hFF;
        endcase
    endfunction

    function automatic logic [7:0] random_unknown_op();
        logic [7:0] op;
        op = 8'($urandom());
        while (is_known_op(op)) begin
            op = 8'($urandom());
        end
        return op;
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    // ========================================================================
    // SPI host
    // ========================================================================
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] shift;
        shift = tx;
        rx    = 8'h00;
        @(posedge clk);
        spi_ss_n <= 1'b0;
        spi_mosi <= shift[7];
        repeat (8) begin
            repeat (HALF_SCLK) @(posedge clk);
            spi_sclk <= 1'b1;
            rx = {rx[6:0], spi_miso};
            repeat (HALF_SCLK) @(posedge clk);
            spi_sclk <= 1'b0;
            shift = {shift[6:0], 1'b0};
            spi_mosi <= shift[7];
        end
        repeat (HALF_SCLK) @(posedge clk);
        spi_ss_n <= 1'b1;
        repeat (IDLE_CLK) @(posedge clk);
    endtask

    // reply to the previous byte comes back during this one
    task automatic send_byte(input logic [7:0] b, input logic [7:0] next_exp);
        logic [7:0] rx;
        spi_xfer(b, rx);
        check_byte(rx, exp_reply, "reply byte");
        exp_reply = next_exp;
    endtask

    task automatic run_cmd(input logic [7:0] op);
        if (op == dbg_pkg::CMD_TOGGLE_LED) begin
            m_led = ~m_led;
        end
        send_byte(op, idle_reply(op));
        check_byte(8'(led), 8'(m_led), "led state");
        check_byte(8'(flash_cs_n), 8'd1, "flash_cs_n between reads");
    endtask

    task automatic echo_byte(input logic [7:0] data);
        send_byte(dbg_pkg::CMD_ECHO, 8'h01);
        send_byte(data, data);
    endtask

    task automatic read_flash(input logic [23:0] addr);
        logic [7:0] rx;
        int         polls;
        exp_addr = addr;
        polls    = 0;
        send_byte(dbg_pkg::CMD_READ_FLASH, 8'd3);
        send_byte(addr[23:16], 8'd2);
        send_byte(addr[15:8], 8'd1);
        send_byte(addr[7:0], 8'd0);
        // first poll only returns the last address reply
        send_byte(dbg_pkg::CMD_NOP, dbg_pkg::REPLY_BUSY);
        spi_xfer(dbg_pkg::CMD_NOP, rx);
        while (rx !== dbg_pkg::REPLY_READY) begin
            check_byte(rx, dbg_pkg::REPLY_BUSY, "flash busy reply");
            polls++;
            check_byte(8'(polls > MAX_POLLS), 8'd0, "flash read exceeded poll limit");
            spi_xfer(dbg_pkg::CMD_NOP, rx);
        end
        exp_reply = flash_pattern(addr);
        check_byte(8'(flash_cs_n), 8'd1, "flash_cs_n after read");
    endtask

    task automatic run_mix_op();
        case ($urandom_range(0, 5))
            0:       run_cmd(dbg_pkg::CMD_NOP);
            1:       echo_byte(8'($urandom()));
            2:       run_cmd(dbg_pkg::CMD_TOGGLE_LED);
            3:       run_cmd(dbg_pkg::CMD_ECHO_CC);
            4:       run_cmd(random_unknown_op());
            default: read_flash(24'($urandom()));
        endcase
    endtask

    // ========================================================================
    // serial flash model, mode 0
    // ========================================================================
    always @(posedge flash_sclk or posedge flash_cs_n) begin
        if (flash_cs_n) begin
            fl_count = 0;
        end else begin
            if (fl_count < dbg_pkg::FLASH_OUT_BITS) begin
                fl_shift = {fl_shift[30:0], flash_mosi};
            end
            fl_count = fl_count + 1;
            if (fl_count == dbg_pkg::FLASH_OUT_BITS) begin
                check_byte(fl_shift[31:24], dbg_pkg::FLASH_READ_OP, "flash opcode");
                check_byte(fl_shift[23:16], exp_addr[23:16], "flash address high");
                check_byte(fl_shift[15:8], exp_addr[15:8], "flash address mid");
                check_byte(fl_shift[7:0], exp_addr[7:0], "flash address low");
                fl_data = flash_pattern(fl_shift[23:0]);
            end
        end
    end

    always @(negedge flash_sclk) begin
        if (!flash_cs_n && fl_count >= dbg_pkg::FLASH_OUT_BITS &&
            fl_count < dbg_pkg::FLASH_CYCLES) begin
            flash_miso <= fl_data[dbg_pkg::FLASH_CYCLES - 1 - fl_count];
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        int n_toggle;
        rst       = 1'b1;
        spi_sclk  = 1'b0;
        spi_mosi  = 1'b0;
        spi_ss_n  = 1'b1;
        m_led     = 1'b0;
        exp_reply = dbg_pkg::REPLY_ZERO;
        exp_addr  = 24'd0;
        void'($urandom(51));

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_byte(8'(led), 8'd0, "led after reset");
        check_byte(8'(flash_cs_n), 8'd1, "flash_cs_n after reset");
        check_byte(8'(flash_sclk), 8'd0, "flash_sclk after reset");
        check_byte(8'(spi_miso), 8'd0, "spi_miso after reset");
        repeat (N_NOP) run_cmd(dbg_pkg::CMD_NOP);

        repeat (N_ECHO) echo_byte(8'($urandom()));
        repeat (N_CC) run_cmd(dbg_pkg::CMD_ECHO_CC);

        // bad opcode must leave the decoder idle
        repeat (N_BAD) begin
            run_cmd(random_unknown_op());
            run_cmd(dbg_pkg::CMD_NOP);
        end

        n_toggle = int'($urandom_range(1, N_TOGGLE));
        repeat (n_toggle) run_cmd(dbg_pkg::CMD_TOGGLE_LED);

        repeat (N_READ) read_flash(24'($urandom()));

        repeat (N_MIX) run_mix_op();

        // flush the reply to the last command
        run_cmd(dbg_pkg::CMD_NOP);

        if (dut.u_checker.fail_count != 0) begin
            $display("bound assertions failed %0d times during the run",
                     dut.u_checker.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout at %0t ns, the test sequence did not complete", $time);
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: dbg_bridge.f
design/dbg_pkg.sv
design/byte_link_if.sv
design/flash_req_if.sv
design/bit_timer.sv
design/spi_target.sv
design/dbg_cmd_fsm.sv
design/flash_reader.sv
design/dbg_bridge.sv
sim/dbg_bridge_checker.sv
sim/dbg_bridge_tb.sv
